// File: rtl/i2c_params.svh
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// default system clock and scl rate, in Hz.
`define I2C_CLK_FREQ 32'd50_000_000
`define I2C_SCL_FREQ 32'd100_000

// register offsets, decoded from addr[19:16].
`define I2C_REG_ADDR  4'h1
`define I2C_REG_WDATA 4'h2
`define I2C_REG_RDATA 4'h3
`define I2C_REG_CONF  4'h4

// data bytes per burst.
`define I2C_MAX_LEN 4

`endif

// File: rtl/i2c_bus_pkg.sv
`include "i2c_params.svh"

package i2c_bus_pkg;

    // configuration and status word.
    typedef struct packed {
        logic [21:0] rsvd1;
        logic        nack;    // bit 9, read only.
        logic        busy;    // bit 8, read only.
        logic [3:0]  rsvd0;
        logic [1:0]  len_m1;  // byte count minus one.
        logic        rw;      // 1 reads.
        logic        start;   // self clearing.
    } i2c_conf_t;

    typedef struct packed {
        logic [15:0] rsvd1;
        logic [7:0]  sub;
        logic        rsvd0;
        logic [6:0]  slave;
    } i2c_addr_t;

    // one transaction, latched by the byte controller at launch.
    typedef struct packed {
        logic [6:0]                    slave;
        logic [7:0]                    sub;
        logic                          rw;
        logic [1:0]                    len_m1;
        logic [`I2C_MAX_LEN * 8 - 1:0] wdata;   // lsb byte goes first.
        logic [4:0]                    pad;
    } i2c_xfer_t;

    typedef struct packed {
        logic [`I2C_MAX_LEN * 8 - 1:0] rdata;
        logic                          nack;
        logic                          done;
    } i2c_result_t;

endpackage

// File: rtl/i2c_line_pkg.sv
package i2c_line_pkg;

    // one bus condition or one data bit.
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_bit_cmd_e;

    typedef struct packed {
        logic         valid;  // one cycle strobe.
        i2c_bit_cmd_e cmd;
        logic         wbit;
    } i2c_bit_req_t;

    typedef struct packed {
        logic done;  // one cycle strobe.
        logic rbit;
    } i2c_bit_rsp_t;

endpackage

// File: rtl/i2c_regs.sv
`include "i2c_params.svh"

module i2c_regs
    import i2c_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic [31:0] data_i,
    input  logic [31:0] addr_i,
    input  logic        we_i,
    output logic [31:0] data_o,

    output logic        xfer_start_o,
    output i2c_xfer_t   xfer_o,
    input  i2c_result_t result_i
);

    logic [3:0]  reg_sel;
    i2c_addr_t   addr_q, addr_wr;
    i2c_conf_t   conf_q, conf_in, conf_wr, conf_rd;
    logic [31:0] wdata_q, rdata_q;
    logic        busy_q, nack_q, start_q;
    logic        conf_we, launch;

    assign reg_sel = addr_i[19:16];
    assign conf_in = data_i;
    assign conf_we = we_i && (reg_sel == `I2C_REG_CONF) && !busy_q;  // dropped while busy.
    assign launch  = conf_we && conf_in.start;

    // writable fields only.
    always_comb begin
        addr_wr        = data_i;
        addr_wr.rsvd0  = 1'b0;
        addr_wr.rsvd1  = '0;
        conf_wr        = '0;
        conf_wr.rw     = conf_in.rw;
        conf_wr.len_m1 = conf_in.len_m1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
            conf_q  <= '0;
            busy_q  <= 1'b0;
            nack_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= launch;
            if (we_i && reg_sel == `I2C_REG_ADDR) addr_q <= addr_wr;
            if (we_i && reg_sel == `I2C_REG_WDATA) wdata_q <= data_i;
            if (conf_we) conf_q <= conf_wr;
            if (launch) begin
                busy_q <= 1'b1;
                nack_q <= 1'b0;
            end else if (result_i.done) begin
                busy_q <= 1'b0;
                nack_q <= result_i.nack;
                if (conf_q.rw) rdata_q <= result_i.rdata;
            end
        end
    end

    assign xfer_start_o = start_q;
    assign xfer_o = '{
        slave:  addr_q.slave,
        sub:    addr_q.sub,
        rw:     conf_q.rw,
        len_m1: conf_q.len_m1,
        wdata:  wdata_q,
        pad:    '0
    };

    // status merged into the conf word.
    always_comb begin
        conf_rd      = conf_q;
        conf_rd.busy = busy_q;
        conf_rd.nack = nack_q;
    end

    always_comb begin
        data_o = '0;
        if (!we_i) begin
            case (reg_sel)
                `I2C_REG_ADDR:  data_o = addr_q;
                `I2C_REG_WDATA: data_o = wdata_q;
                `I2C_REG_RDATA: data_o = rdata_q;
                `I2C_REG_CONF:  data_o = conf_rd;
                default:        data_o = '0;
            endcase
        end
    end

endmodule

// File: rtl/i2c_clk_gen.sv
module i2c_clk_gen #(
    parameter int unsigned QUARTER = 2
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic en_i,
    output logic tick_o
);

    localparam int unsigned CW = $clog2(QUARTER);

    logic [CW-1:0] cnt_q;

    assign tick_o = en_i && (cnt_q == '0);

    // preload is two short of a full quarter, which covers the request
    // cycle and the enable register, so ticks stay on a Q grid from bit to bit.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= CW'(QUARTER - 2);
        end else if (!en_i) begin
            cnt_q <= CW'(QUARTER - 2);
        end else if (tick_o) begin
            cnt_q <= CW'(QUARTER - 1);
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

// File: rtl/i2c_bit_ctrl.sv
module i2c_bit_ctrl
    import i2c_line_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  i2c_bit_req_t bit_req_i,
    output i2c_bit_rsp_t bit_rsp_o,

    input  logic         tick_i,
    output logic         tick_en_o,

    output logic         scl_o,
    output logic         sda_o,
    output logic         sda_t_o,
    input  logic         sda_i
);

    i2c_bit_cmd_e cmd_q;
    logic         wbit_q, rbit_q;
    logic         busy_q, done_q;
    logic         scl_q, sda_t_q;
    logic [1:0]   phase_q;  // ticks seen so far.
    logic         sda_first;

    // sda level set at tick 1, scl low.
    always_comb begin
        case (cmd_q)
            CMD_STOP:  sda_first = 1'b0;
            CMD_WRITE: sda_first = wbit_q;
            default:   sda_first = 1'b1;  // released.
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            phase_q <= '0;
            scl_q   <= 1'b1;
            sda_t_q <= 1'b1;
        end else begin
            done_q <= 1'b0;
            if (bit_req_i.valid) begin
                busy_q  <= 1'b1;
                phase_q <= '0;
                scl_q   <= 1'b0;
            end else if (busy_q && tick_i) begin
                phase_q <= phase_q + 2'd1;
                case (phase_q)
                    2'd0: sda_t_q <= sda_first;
                    2'd1: scl_q <= 1'b1;
                    2'd2: begin
                        // start and stop conditions, scl high.
                        if (cmd_q == CMD_START) sda_t_q <= 1'b0;
                        if (cmd_q == CMD_STOP) sda_t_q <= 1'b1;
                    end
                    default: begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                        if (cmd_q == CMD_START) scl_q <= 1'b0;  // hold the bus after start.
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bit_req_i.valid) begin
            cmd_q  <= bit_req_i.cmd;
            wbit_q <= bit_req_i.wbit;
        end
        if (busy_q && tick_i && phase_q == 2'd2 && cmd_q == CMD_READ) rbit_q <= sda_i;
    end

    assign tick_en_o = busy_q;
    assign bit_rsp_o = '{done: done_q, rbit: rbit_q};

    assign scl_o   = scl_q;
    assign sda_o   = 1'b0;  // open drain, only the enable moves.
    assign sda_t_o = sda_t_q;

endmodule

// File: rtl/i2c_byte_ctrl.sv
module i2c_byte_ctrl
    import i2c_bus_pkg::*, i2c_line_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         xfer_start_i,
    input  i2c_xfer_t    xfer_i,
    output i2c_result_t  result_o,

    output i2c_bit_req_t bit_req_o,
    input  i2c_bit_rsp_t bit_rsp_i
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        WRITE_ADDR,
        WRITE_SUB,
        RESTART,
        REWRITE_ADDR,
        WRITE_BYTE,
        READ_BYTE,
        READ_LAST_BYTE,
        STOP
    } state_e;

    state_e      state_q, state_d;
    logic [3:0]  bit_cnt_q, bit_cnt_d;  // 0 to 7 data, 8 ack.
    logic [1:0]  byte_q, byte_d;
    i2c_xfer_t   xfer_q;
    logic [31:0] rdata_q;
    logic        nack_q, done_q;
    logic        launch, last_bit, rx_bit, set_nack, issue;
    logic [7:0]  tx_byte;

    assign launch   = (state_q == IDLE) && xfer_start_i;
    assign last_bit = bit_cnt_q[3];
    assign rx_bit   = (state_q == READ_BYTE || state_q == READ_LAST_BYTE) && !last_bit;

    always_comb begin
        state_d   = state_q;
        bit_cnt_d = bit_cnt_q;
        byte_d    = byte_q;
        set_nack  = 1'b0;
        if (launch) begin
            state_d   = START;
            bit_cnt_d = '0;
            byte_d    = '0;
        end else if (bit_rsp_i.done) begin
            bit_cnt_d = '0;
            case (state_q)
                START:   state_d = WRITE_ADDR;
                RESTART: state_d = REWRITE_ADDR;
                STOP:    state_d = IDLE;
                WRITE_ADDR, WRITE_SUB, REWRITE_ADDR, WRITE_BYTE: begin
                    if (!last_bit) begin
                        bit_cnt_d = bit_cnt_q + 4'd1;
                    end else if (bit_rsp_i.rbit) begin
                        state_d  = STOP;  // slave did not ack.
                        set_nack = 1'b1;
                    end else begin
                        case (state_q)
                            WRITE_ADDR: state_d = WRITE_SUB;
                            WRITE_SUB:  state_d = xfer_q.rw ? RESTART : WRITE_BYTE;
                            REWRITE_ADDR: begin
                                state_d = (xfer_q.len_m1 == 2'd0) ? READ_LAST_BYTE : READ_BYTE;
                            end
                            default: begin
                                if (byte_q == xfer_q.len_m1) state_d = STOP;
                                else byte_d = byte_q + 2'd1;
                            end
                        endcase
                    end
                end
                READ_BYTE: begin
                    if (!last_bit) begin
                        bit_cnt_d = bit_cnt_q + 4'd1;
                    end else begin
                        byte_d  = byte_q + 2'd1;
                        state_d = (byte_d == xfer_q.len_m1) ? READ_LAST_BYTE : READ_BYTE;
                    end
                end
                READ_LAST_BYTE: begin
                    if (!last_bit) bit_cnt_d = bit_cnt_q + 4'd1;
                    else state_d = STOP;
                end
                default: state_d = IDLE;
            endcase
        end
    end

    // next request goes out in the done cycle, keeping scl periodic.
    assign issue = launch || (bit_rsp_i.done && state_d != IDLE);

    always_comb begin
        case (state_d)
            WRITE_ADDR:   tx_byte = {xfer_q.slave, 1'b0};
            REWRITE_ADDR: tx_byte = {xfer_q.slave, 1'b1};
            WRITE_SUB:    tx_byte = xfer_q.sub;
            default:      tx_byte = xfer_q.wdata[{byte_d, 3'b000} +: 8];
        endcase
        bit_req_o.valid = issue;
        bit_req_o.cmd   = CMD_READ;  // ack slot of a sent byte.
        bit_req_o.wbit  = 1'b1;
        case (state_d)
            START, RESTART: bit_req_o.cmd = CMD_START;
            STOP:           bit_req_o.cmd = CMD_STOP;
            READ_BYTE, READ_LAST_BYTE: begin
                if (bit_cnt_d[3]) begin
                    bit_req_o.cmd  = CMD_WRITE;
                    bit_req_o.wbit = (state_d == READ_LAST_BYTE);  // nack ends the read.
                end
            end
            default: begin
                if (!bit_cnt_d[3]) begin
                    bit_req_o.cmd  = CMD_WRITE;
                    bit_req_o.wbit = tx_byte[3'd7 - bit_cnt_d[2:0]];  // msb first.
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            byte_q    <= '0;
            nack_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            bit_cnt_q <= bit_cnt_d;
            byte_q    <= byte_d;
            done_q    <= (state_q == STOP) && bit_rsp_i.done;
            if (launch) nack_q <= 1'b0;
            else if (set_nack) nack_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            xfer_q  <= xfer_i;
            rdata_q <= '0;
        end else if (bit_rsp_i.done && rx_bit) begin
            rdata_q[{byte_q, 3'd7 - bit_cnt_q[2:0]}] <= bit_rsp_i.rbit;
        end
    end

    assign result_o = '{rdata: rdata_q, nack: nack_q, done: done_q};

endmodule

// File: rtl/i2c.sv
`include "i2c_params.svh"

module i2c
    import i2c_bus_pkg::*, i2c_line_pkg::*;
#(
    parameter int unsigned CLK_FREQ = `I2C_CLK_FREQ,
    parameter int unsigned SCL_FREQ = `I2C_SCL_FREQ
) (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic [31:0] data_i,
    input  logic [31:0] addr_i,
    input  logic        we_i,
    output logic [31:0] data_o,

    output logic        scl_o,
    output logic        sda_o,
    output logic        sda_t_o,
    input  logic        sda_i
);

    // four ticks per scl period.
    localparam int unsigned QUARTER = CLK_FREQ / (4 * SCL_FREQ);

    logic         xfer_start;
    i2c_xfer_t    xfer;
    i2c_result_t  result;
    i2c_bit_req_t bit_req;
    i2c_bit_rsp_t bit_rsp;
    logic         tick, tick_en;

    i2c_regs u_regs (
        .clk_i,
        .rst_ni,
        .data_i,
        .addr_i,
        .we_i,
        .data_o,
        .xfer_start_o (xfer_start),
        .xfer_o       (xfer),
        .result_i     (result)
    );

    i2c_byte_ctrl u_byte_ctrl (
        .clk_i,
        .rst_ni,
        .xfer_start_i (xfer_start),
        .xfer_i       (xfer),
        .result_o     (result),
        .bit_req_o    (bit_req),
        .bit_rsp_i    (bit_rsp)
    );

    i2c_bit_ctrl u_bit_ctrl (
        .clk_i,
        .rst_ni,
        .bit_req_i (bit_req),
        .bit_rsp_o (bit_rsp),
        .tick_i    (tick),
        .tick_en_o (tick_en),
        .scl_o,
        .sda_o,
        .sda_t_o,
        .sda_i
    );

    i2c_clk_gen #(
        .QUARTER (QUARTER)
    ) u_clk_gen (
        .clk_i,
        .rst_ni,
        .en_i   (tick_en),
        .tick_o (tick)
    );

endmodule

// File: testbench/i2c_checker.sv
module i2c_checker
    import i2c_line_pkg::*;
(
    input logic         clk_i,
    input logic         rst_ni,
    input logic         scl_o,
    input logic         sda_t_o,
    input logic         tick_en_o,
    input i2c_bit_req_t bit_req_i,
    input i2c_bit_rsp_t bit_rsp_o,
    input i2c_bit_cmd_e cmd_q
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;

    // sda may move with scl high only for start and stop.
    sda_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ($changed(sda_t_o) && scl_o && $past(scl_o)) |-> (cmd_q inside {CMD_START, CMD_STOP}))
        else begin
            $error("sda changed while scl high outside start or stop");
            fail_cnt++;
        end

    req_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        bit_req_i.valid |-> !tick_en_o)
        else begin
            $error("bit request while a bit is in progress");
            fail_cnt++;
        end

    done_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        bit_rsp_o.done |=> !bit_rsp_o.done)
        else begin
            $error("bit done wider than one cycle");
            fail_cnt++;
        end

endmodule

bind i2c_bit_ctrl i2c_checker u_checker (.*);

// File: testbench/i2c_monitor.sv
module i2c_monitor #(
    parameter int unsigned PERIOD_NS = 80
) (
    input  logic        clk_i,
    input  logic [31:0] rdata_i,
    input  logic        check_i,
    input  logic [31:0] exp_i,
    input  logic        per_valid_i,
    input  int unsigned per_ns_i,
    input  logic        test_end_i,
    input  int unsigned test_id_i,
    input  logic        final_i,
    output int unsigned errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned checks, test_errs, tests, tests_bad;

    initial begin
        errors_o  = 0;
        checks    = 0;
        test_errs = 0;
        tests     = 0;
        tests_bad = 0;
    end

    always @(posedge clk_i) begin
        if (check_i) begin
            checks++;
            if (rdata_i !== exp_i) begin
                $display("MISMATCH at %0t ns: read %h, expected %h", $time, rdata_i, exp_i);
                errors_o++;
                test_errs++;
            end
        end
        if (per_valid_i) begin
            checks++;
            if (per_ns_i != PERIOD_NS) begin
                $display("MISMATCH at %0t ns: scl period %0d ns, expected %0d ns",
                         $time, per_ns_i, PERIOD_NS);
                errors_o++;
                test_errs++;
            end
        end
        if (test_end_i) begin
            tests++;
            if (test_errs != 0) tests_bad++;
            $display("test %0d: %s, %0d errors", test_id_i, (test_errs == 0) ? "ok" : "FAILED",
                     test_errs);
            test_errs = 0;
        end
        if (final_i) begin
            $display("%0d tests, %0d failed, %0d checks, %0d errors",
                     tests, tests_bad, checks, errors_o);
        end
    end

endmodule

// File: testbench/i2c_tb.sv
`include "i2c_params.svh"

module i2c_tb
    import i2c_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_FREQ   = 8_000_000;
    localparam int unsigned SCL_FREQ   = 1_000_000;
    localparam int unsigned Q          = CLK_FREQ / (4 * SCL_FREQ);
    localparam logic [6:0]  SLAVE_ADDR = 7'h50;
    localparam int unsigned NBURST     = 6;
    localparam int unsigned NTRANS     = 2 * NBURST + 8;
    localparam int unsigned WATCHDOG_NS = NTRANS * 75 * 4 * Q * 10 + 20_000;
    localparam int unsigned S_IDLE = 0, S_ADDR = 1, S_SUB = 2, S_DATA = 3;

    logic        clk_i, rst_ni, we_i, sda_i, scl_o, sda_o, sda_t_o;
    logic [31:0] data_i, addr_i, data_o;
    logic        chk, test_end, fin, per_valid, per_pend, slv_drv;
    logic [31:0] chk_exp, lfsr_q;
    int unsigned test_id, per_ns, errors, fails;
    logic [7:0]  mem [256];
    logic [7:0]  shadow [256];
    logic [7:0]  rx, tx, ptr;
    int unsigned bitn, st;
    logic        sending, pend_rd, in_frame;
    time         last_rise, per_meas;

    assign sda_i = (sda_t_o ? 1'b1 : sda_o) & slv_drv;

    i2c #(.CLK_FREQ(CLK_FREQ), .SCL_FREQ(SCL_FREQ)) UUT (.*);

    i2c_monitor #(.PERIOD_NS(4 * Q * 10)) u_mon (
        .clk_i, .rdata_i(data_o), .check_i(chk), .exp_i(chk_exp),
        .per_valid_i(per_valid), .per_ns_i(per_ns), .test_end_i(test_end),
        .test_id_i(test_id), .final_i(fin), .errors_o(errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // open-drain slave with a 256-byte memory.
    initial begin
        slv_drv  = 1'b1;
        st       = S_IDLE;
        bitn     = 0;
        sending  = 1'b0;
        pend_rd  = 1'b0;
        in_frame = 1'b0;
        per_pend = 1'b0;
        ptr      = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = 8'(i * 29) ^ 8'ha7;
            shadow[i] = 8'(i * 29) ^ 8'ha7;
        end
    end

    always @(negedge sda_i) begin
        if (scl_o === 1'b1) begin  // start.
            st       = S_ADDR;
            bitn     = 0;
            sending  = 1'b0;
            pend_rd  = 1'b0;
            in_frame = 1'b1;
        end
    end

    always @(posedge sda_i) begin
        if (scl_o === 1'b1) begin  // stop.
            st       = S_IDLE;
            in_frame = 1'b0;
        end
    end

    always @(posedge scl_o) begin
        if (in_frame && bitn > 0 && bitn <= 8) begin
            per_meas = $time - last_rise;
            per_pend = 1'b1;
        end
        last_rise = $time;
        if (bitn < 8) begin
            if (!sending) rx = {rx[6:0], sda_i};
            bitn++;
        end else begin
            bitn = 0;
            if (pend_rd) begin
                sending = 1'b1;
                pend_rd = 1'b0;
                tx      = mem[ptr];
            end else if (sending) begin
                ptr++;
                if (sda_i) begin  // master nack ends the read.
                    sending = 1'b0;
                    st      = S_IDLE;
                end else begin
                    tx = mem[ptr];
                end
            end
        end
    end

    always @(negedge scl_o) begin
        slv_drv = 1'b1;
        if (sending) begin
            if (bitn < 8) slv_drv = tx[7 - bitn];
        end else if (bitn == 8) begin
            case (st)
                S_ADDR: begin
                    if (rx[7:1] == SLAVE_ADDR) begin
                        slv_drv = 1'b0;
                        pend_rd = rx[0];
                        st      = rx[0] ? S_IDLE : S_SUB;
                    end else begin
                        st = S_IDLE;
                    end
                end
                S_SUB: begin
                    ptr     = rx;
                    st      = S_DATA;
                    slv_drv = 1'b0;
                end
                S_DATA: begin
                    mem[ptr] = rx;
                    ptr++;
                    slv_drv  = 1'b0;
                end
                default: ;
            endcase
        end
    end

    always @(negedge clk_i) begin
        per_valid = per_pend;
        per_ns    = int'(per_meas);
        per_pend  = 1'b0;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // expected {nack, rdata}; a write updates the shadow memory.
    function automatic logic [32:0] ref_xfer(input logic [6:0] slv, input logic [7:0] sub,
                                            input logic rw, input logic [1:0] len_m1,
                                            input logic [31:0] wdata);
        logic [31:0] rd;
        logic [7:0]  a;
        rd = '0;
        if (slv != SLAVE_ADDR) return {1'b1, 32'h0};
        for (int i = 0; i <= int'(len_m1); i++) begin
            a = sub + 8'(i);
            if (rw) rd[8 * i +: 8] = shadow[a];
            else shadow[a] = wdata[8 * i +: 8];
        end
        return {1'b0, rd};
    endfunction

    task automatic bus_write(input logic [3:0] off, input logic [31:0] val);
        @(negedge clk_i);
        addr_i = {12'h0, off, 16'h0};
        data_i = val;
        we_i   = 1'b1;
        @(negedge clk_i);
        we_i = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] off, input logic [31:0] val);
        @(negedge clk_i);
        addr_i  = {12'h0, off, 16'h0};
        we_i    = 1'b0;
        chk_exp = val;
        chk     = 1'b1;
        @(negedge clk_i);
        chk = 1'b0;
    endtask

    task automatic wait_idle();
        i2c_conf_t c;
        int        n;
        n = 0;
        @(negedge clk_i);
        addr_i = {12'h0, `I2C_REG_CONF, 16'h0};
        we_i   = 1'b0;
        do begin
            @(negedge clk_i);
            c = data_o;
            n++;
        end while (c.busy && n < 2000);
        if (c.busy) begin
            $display("transaction did not finish, busy still set after %0d polls", n);
            fails++;
        end
    endtask

    task automatic launch_xfer(input logic [6:0] slv, input logic [7:0] sub, input logic rw,
                               input logic [1:0] len_m1, input logic [31:0] wdata);
        i2c_conf_t c;
        c        = '0;
        c.start  = 1'b1;
        c.rw     = rw;
        c.len_m1 = len_m1;
        bus_write(`I2C_REG_ADDR, {16'h0, sub, 1'b0, slv});
        bus_write(`I2C_REG_WDATA, wdata);
        bus_write(`I2C_REG_CONF, c);
    endtask

    task automatic finish_xfer(input logic [6:0] slv, input logic [7:0] sub, input logic rw,
                               input logic [1:0] len_m1, input logic [31:0] wdata);
        i2c_conf_t   c;
        logic [32:0] exp;
        wait_idle();
        exp      = ref_xfer(slv, sub, rw, len_m1, wdata);
        c        = '0;
        c.rw     = rw;
        c.len_m1 = len_m1;
        c.nack   = exp[32];
        read_check(`I2C_REG_CONF, c);
        if (rw) read_check(`I2C_REG_RDATA, exp[31:0]);
    endtask

    task automatic end_test(input int unsigned id);
        @(negedge clk_i);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clk_i);
        test_end = 1'b0;
    endtask

    initial begin
        logic [31:0] r_sub, r_len, r_dat;
        int unsigned total;
        rst_ni   = 1'b0;
        data_i   = '0;
        addr_i   = '0;
        we_i     = 1'b0;
        chk      = 1'b0;
        chk_exp  = '0;
        test_end = 1'b0;
        test_id  = 0;
        fin      = 1'b0;
        fails    = 0;
        lfsr_q   = 32'h2665;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        if (scl_o !== 1'b1 || sda_t_o !== 1'b1 || sda_o !== 1'b0) begin
            $display("MISMATCH at %0t ns: scl %b sda_t %b sda %b after reset", $time, scl_o,
                     sda_t_o, sda_o);
            fails++;
        end
        for (int r = 1; r <= 4; r++) read_check(4'(r), 32'h0);
        end_test(1);

        bus_write(`I2C_REG_ADDR, 32'hffff_ffff);
        read_check(`I2C_REG_ADDR, 32'h0000_ff7f);
        bus_write(`I2C_REG_WDATA, 32'hffff_ffff);
        read_check(`I2C_REG_WDATA, 32'hffff_ffff);
        bus_write(`I2C_REG_CONF, 32'hffff_fffe);
        read_check(`I2C_REG_CONF, 32'h0000_000e);
        bus_write(`I2C_REG_RDATA, 32'hdead_beef);
        read_check(`I2C_REG_RDATA, 32'h0);
        end_test(2);

        for (int n = 0; n < NBURST; n++) begin
            rand_bits(8, r_sub);
            rand_bits(2, r_len);
            rand_bits(32, r_dat);
            launch_xfer(SLAVE_ADDR, r_sub[7:0], 1'b0, r_len[1:0], r_dat);
            finish_xfer(SLAVE_ADDR, r_sub[7:0], 1'b0, r_len[1:0], r_dat);
            launch_xfer(SLAVE_ADDR, r_sub[7:0], 1'b1, r_len[1:0], 32'h0);
            finish_xfer(SLAVE_ADDR, r_sub[7:0], 1'b1, r_len[1:0], 32'h0);
        end
        end_test(3);

        launch_xfer(7'h23, r_sub[7:0], 1'b0, 2'd3, 32'h1122_3344);
        finish_xfer(7'h23, r_sub[7:0], 1'b0, 2'd3, 32'h1122_3344);
        launch_xfer(7'h23, r_sub[7:0], 1'b1, 2'd3, 32'h0);
        finish_xfer(7'h23, r_sub[7:0], 1'b1, 2'd3, 32'h0);
        launch_xfer(SLAVE_ADDR, r_sub[7:0], 1'b1, 2'd3, 32'h0);
        finish_xfer(SLAVE_ADDR, r_sub[7:0], 1'b1, 2'd3, 32'h0);
        end_test(4);

        launch_xfer(SLAVE_ADDR, 8'h40, 1'b0, 2'd1, 32'h0000_c3a5);
        bus_write(`I2C_REG_CONF, 32'h0000_000f);  // second start, dropped.
        finish_xfer(SLAVE_ADDR, 8'h40, 1'b0, 2'd1, 32'h0000_c3a5);
        launch_xfer(SLAVE_ADDR, 8'h40, 1'b1, 2'd1, 32'h0);
        finish_xfer(SLAVE_ADDR, 8'h40, 1'b1, 2'd1, 32'h0);
        end_test(5);

        launch_xfer(SLAVE_ADDR, 8'hfe, 1'b1, 2'd3, 32'h0);
        finish_xfer(SLAVE_ADDR, 8'hfe, 1'b1, 2'd3, 32'h0);
        end_test(6);

        @(negedge clk_i);
        fin = 1'b1;
        @(negedge clk_i);
        fin = 1'b0;
        total = errors + fails + UUT.u_bit_ctrl.u_checker.fail_cnt;
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: i2c.f
+incdir+rtl
rtl/i2c_bus_pkg.sv
rtl/i2c_line_pkg.sv
rtl/i2c_regs.sv
rtl/i2c_clk_gen.sv
rtl/i2c_bit_ctrl.sv
rtl/i2c_byte_ctrl.sv
rtl/i2c.sv
testbench/i2c_checker.sv
testbench/i2c_monitor.sv
testbench/i2c_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f i2c.f --top-module i2c_tb -o i2c_tb
	./obj_dir/i2c_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
